// ==== Bender.yml ====
package:
  name: posit_mac

sources:
  - verilog/posit_mac_pkg.sv
  - verilog/posit_decoder.sv
  - verilog/product_aligner.sv
  - verilog/quire_accumulator.sv
  - verilog/posit_encoder.sv
  - verilog/posit_mac_top.sv
  - target: test
    files:
      - verif/tb_posit_mac.sv

// ==== posit_mac_top.f ====
verilog/posit_mac_pkg.sv
verilog/posit_decoder.sv
verilog/product_aligner.sv
verilog/quire_accumulator.sv
verilog/posit_encoder.sv
verilog/posit_mac_top.sv
verif/tb_posit_mac.sv

// ==== verif/tb_posit_mac.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_posit_mac;

    localparam int PW         = posit_mac_pkg::POSIT_W;
    localparam int ACC_LEN    = 4;
    localparam int LATENCY    = 5;      // edges from last product to vld_o
    localparam int NUM_ROWS   = 10;
    localparam int NUM_B2B    = 5;
    localparam int MAX_CYCLES = (NUM_ROWS + NUM_B2B) * 10 + 20;

    // one group of products and its posit result
    typedef struct packed {
        logic [ACC_LEN-1:0][PW-1:0] weight;
        logic [ACC_LEN-1:0][PW-1:0] data;
        logic [PW-1:0]              expected;
    } mac_row_t;

    logic          clk_i;
    logic          rstn;
    logic          vld_i;
    logic [PW-1:0] weight_i;
    logic [PW-1:0] data_i;
    logic [PW-1:0] acc_o;
    logic          vld_o;

    mac_row_t vectors [NUM_ROWS];
    string    labels [NUM_ROWS];
    int       b2b_rows [NUM_B2B];
    int       due_q [$];        // edge at which each result is due
    int       row_q [$];
    int       cycle_cnt = 0;
    int       pass_cnt = 0;
    int       fail_cnt = 0;

    posit_mac_top #(
        .ACC_LEN (ACC_LEN)
    ) UUT (
        .clk_i    (clk_i),
        .rstn     (rstn),
        .vld_i    (vld_i),
        .weight_i (weight_i),
        .data_i   (data_i),
        .acc_o    (acc_o),
        .vld_o    (vld_o)
    );

    initial clk_i = 1'b0;
    always #2 clk_i = ~clk_i;

    always @(posedge clk_i) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    // ------------------------------
    // stimulus table
    // ------------------------------
    task automatic set_row(input int idx, input string name, input logic [ACC_LEN*PW-1:0] w,
                           input logic [ACC_LEN*PW-1:0] d, input logic [PW-1:0] result);
        vectors[idx].weight   = w;
        vectors[idx].data     = d;
        vectors[idx].expected = result;
        labels[idx]           = name;
    endtask

    task automatic load_table();
        set_row(0, "4 x 1.0 = 4.0",      32'h40404040, 32'h40404040, 8'h50);
        set_row(1, "2.0 + 3 x 1.0 = 5",  32'h48404040, 32'h40404040, 8'h52);
        set_row(2, "1 - 1 + 2 - 2 = 0",  32'h40c048b8, 32'h40404040, 8'h00);
        set_row(3, "4 x -1.0 = -4.0",    32'hc0c0c0c0, 32'h40404040, 8'hb0);
        set_row(4, "19 rounds up",       32'h60404040, 32'h40404040, 8'h61);
        set_row(5, "17 rounds down",     32'h60400000, 32'h40404040, 8'h60);
        set_row(6, "tie 18 to even",     32'h60404000, 32'h40404040, 8'h60);
        set_row(7, "maxpos saturates",   32'h7f7f7f7f, 32'h7f7f7f7f, 8'h7f);
        set_row(8, "-maxpos saturates",  32'h81818181, 32'h7f7f7f7f, 8'h81);
        set_row(9, "minpos underflows",  32'h01010101, 32'h01010101, 8'h00);
        // exact sums and rounding, no gap between groups
        b2b_rows[0] = 0;
        b2b_rows[1] = 1;
        b2b_rows[2] = 4;
        b2b_rows[3] = 5;
        b2b_rows[4] = 6;
    endtask

    // ------------------------------
    // drive and check
    // ------------------------------
    task automatic drive_row(input int r);
        for (int p = ACC_LEN - 1; p >= 0; p--) begin
            @(posedge clk_i);
            vld_i    <= 1'b1;
            weight_i <= vectors[r].weight[p];
            data_i   <= vectors[r].data[p];
        end
        due_q.push_back(cycle_cnt + 1 + LATENCY);   // counter steps at this edge too
        row_q.push_back(r);
    endtask

    task automatic wait_for_results();
        while (due_q.size() > 0) begin
            @(posedge clk_i);
        end
    endtask

    task automatic check_result();
        int r;
        int due;
        r   = row_q.pop_front();
        due = due_q.pop_front();
        if (acc_o !== vectors[r].expected) begin
            $display("** Error: row %0d (%s) at cycle %0d: acc_o expected %h, got %h",
                     r, labels[r], due, vectors[r].expected, acc_o);
            fail_cnt++;
        end else begin
            $display("row %0d (%s): acc_o = %h ok", r, labels[r], acc_o);
            pass_cnt++;
        end
    endtask

    task automatic report_missing();
        int r;
        int due;
        r   = row_q.pop_front();
        due = due_q.pop_front();
        $display("row %0d (%s): no vld_o pulse at cycle %0d", r, labels[r], due);
        fail_cnt++;
    endtask

    task automatic check_reset_state();
        if (vld_o !== 1'b0) begin
            $display("** Error: reset state: vld_o expected %h, got %h", 1'b0, vld_o);
            fail_cnt++;
        end else if (acc_o !== '0) begin
            $display("** Error: reset state: acc_o expected %h, got %h", 8'h00, acc_o);
            fail_cnt++;
        end else begin
            $display("reset state: vld_o = 0, acc_o = %h ok", acc_o);
            pass_cnt++;
        end
    endtask

    // outputs are looked at on the falling edge
    always @(negedge clk_i) begin
        if (rstn) begin
            if (vld_o && (due_q.size() > 0) && (cycle_cnt == due_q[0])) begin
                check_result();
            end else if (vld_o) begin
                $display("vld_o pulsed at cycle %0d with no result due", cycle_cnt);
                fail_cnt++;
            end else if ((due_q.size() > 0) && (cycle_cnt >= due_q[0])) begin
                report_missing();
            end
        end
    end

    always @(posedge clk_i) begin
        if (cycle_cnt >= MAX_CYCLES) begin
            $display("timeout after %0d cycles, results still pending: %0d",
                     cycle_cnt, due_q.size());
            $display("Simulation FAILED");
            $finish;
        end
    end

    initial begin
        rstn     = 1'b0;
        vld_i    = 1'b0;
        weight_i = '0;
        data_i   = '0;
        load_table();
        repeat (3) @(posedge clk_i);
        rstn <= 1'b1;
        @(negedge clk_i);
        check_reset_state();

        // one group at a time
        for (int r = 0; r < NUM_ROWS; r++) begin
            drive_row(r);
            @(posedge clk_i);
            vld_i <= 1'b0;
            wait_for_results();
        end

        // groups back to back
        for (int i = 0; i < NUM_B2B; i++) begin
            drive_row(b2b_rows[i]);
        end
        @(posedge clk_i);
        vld_i <= 1'b0;
        wait_for_results();

        $display("checks passed: %0d, failed: %0d", pass_cnt, fail_cnt);
        if (fail_cnt == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog/posit_decoder.sv ====
`timescale 1ns/100ps
`default_nettype none

module posit_decoder (
    input  logic                                  clk_i,
    input  logic                                  rstn,
    input  logic                                  vld_i,
    input  logic [posit_mac_pkg::POSIT_W-1:0]     weight_i,
    input  logic [posit_mac_pkg::POSIT_W-1:0]     data_i,
    output posit_mac_pkg::operand_pair_t          pair_o
);

    localparam int PW     = posit_mac_pkg::POSIT_W;
    localparam int ES     = posit_mac_pkg::POSIT_ES;
    localparam int FRAC_W = posit_mac_pkg::FRAC_W;
    localparam int SF_W   = posit_mac_pkg::SF_W;
    localparam int RUN_W  = $clog2(PW);

    logic                    vld_q;
    posit_mac_pkg::decoded_t weight_q;
    posit_mac_pkg::decoded_t data_q;

    // ------------------------------
    // sign, regime, exponent, fraction
    // ------------------------------
    function automatic posit_mac_pkg::decoded_t decode_posit(input logic [PW-1:0] p);
        posit_mac_pkg::decoded_t d;
        logic [PW-1:0]          mag;
        logic [PW-2:0]          body;
        logic [PW-2:0]          rest;
        logic [RUN_W-1:0]       run;
        logic                   run_end;
        logic signed [SF_W-1:0] k;
        d       = '0;
        mag     = p[PW-1] ? -p : p;
        body    = mag[PW-2:0];
        run     = '0;
        run_end = 1'b0;
        // length of the regime run from the top
        for (int i = PW - 2; i >= 0; i--) begin
            if (!run_end && (body[i] == body[PW-2])) begin
                run = run + 1'b1;
            end else begin
                run_end = 1'b1;
            end
        end
        k = body[PW-2] ? $signed(SF_W'(run)) - 1 : -$signed(SF_W'(run));
        rest = body << (run + 1);   // drop regime and terminator, zeros fill in
        d.sign = p[PW-1];
        d.zero = (p == '0);
        d.sf   = (k <<< ES) + SF_W'(rest[PW-2 -: ES]);
        d.frac = {1'b1, rest[PW-2-ES -: FRAC_W]};
        return d;
    endfunction

    always_ff @(posedge clk_i or negedge rstn) begin
        if (!rstn) begin
            vld_q <= 1'b0;
        end else begin
            vld_q <= vld_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (vld_i) begin
            weight_q <= decode_posit(weight_i);
            data_q   <= decode_posit(data_i);
        end
    end

    always_comb begin
        pair_o.vld    = vld_q;
        pair_o.weight = weight_q;
        pair_o.data   = data_q;
    end

endmodule

`default_nettype wire

// ==== verilog/posit_encoder.sv ====
`timescale 1ns/100ps
`default_nettype none

module posit_encoder (
    input  logic                              clk_i,
    input  logic                              rstn,
    input  posit_mac_pkg::quire_word_t        sum_i,
    output logic [posit_mac_pkg::POSIT_W-1:0] acc_o,
    output logic                              vld_o
);

    localparam int PW      = posit_mac_pkg::POSIT_W;
    localparam int ES      = posit_mac_pkg::POSIT_ES;
    localparam int FRAC_W  = posit_mac_pkg::FRAC_W;
    localparam int SF_W    = posit_mac_pkg::SF_W;
    localparam int QUIRE_W = posit_mac_pkg::QUIRE_W;
    localparam int POS_W   = $clog2(QUIRE_W);
    localparam int PAY_W   = ES + FRAC_W + 1;       // exponent, fraction, guard
    localparam int PAT_W   = 2 + PAY_W + PW;        // room for the longest regime

    // ------------------------------
    // stage 1: normalise
    // ------------------------------
    logic [QUIRE_W-1:0]           mag;
    logic [QUIRE_W-1:0]           norm;
    logic [POS_W-1:0]             lead_pos;
    logic signed [SF_W-1:0]       sf;
    posit_mac_pkg::result_class_e res_class;

    logic                         s1_vld_q;
    logic                         sign_q;
    posit_mac_pkg::result_class_e class_q;
    logic signed [SF_W-1:0]       regime_q;
    logic [ES-1:0]                exp_q;
    logic [FRAC_W-1:0]            frac_q;
    logic                         guard_q;
    logic                         sticky_q;

    assign mag = sum_i.value[QUIRE_W-1] ? -sum_i.value : sum_i.value;

    always_comb begin
        lead_pos = '0;
        for (int i = 0; i < QUIRE_W; i++) begin
            if (mag[i]) begin
                lead_pos = POS_W'(i);
            end
        end
    end

    assign sf   = SF_W'(lead_pos) - SF_W'(posit_mac_pkg::QUIRE_FRAC);
    assign norm = mag << (QUIRE_W - 1 - lead_pos);  // leading one to the top

    always_comb begin
        if ((mag == '0) || (sf < -posit_mac_pkg::MAX_SF)) begin
            res_class = posit_mac_pkg::RES_ZERO;
        end else if (sf > posit_mac_pkg::MAX_SF) begin
            res_class = posit_mac_pkg::RES_MAXPOS;
        end else begin
            res_class = posit_mac_pkg::RES_NORMAL;
        end
    end

    always_ff @(posedge clk_i or negedge rstn) begin
        if (!rstn) begin
            s1_vld_q <= 1'b0;
        end else begin
            s1_vld_q <= sum_i.vld;
        end
    end

    always_ff @(posedge clk_i) begin
        if (sum_i.vld) begin
            sign_q   <= sum_i.value[QUIRE_W-1];
            class_q  <= res_class;
            regime_q <= sf >>> ES;          // floor division by 4
            exp_q    <= sf[ES-1:0];
            frac_q   <= norm[QUIRE_W-2 -: FRAC_W];
            guard_q  <= norm[QUIRE_W-2-FRAC_W];
            sticky_q <= |norm[QUIRE_W-3-FRAC_W:0];
        end
    end

    // ------------------------------
    // stage 2: round and pack
    // ------------------------------
    logic signed [PAT_W-1:0] pattern;
    logic [PAT_W-1:0]        shifted;
    logic [PW-2:0]           body;
    logic                    rnd_guard;
    logic                    rnd_sticky;
    logic [PW-1:0]           rounded;
    logic [PW-1:0]           res_mag;
    logic [PW-1:0]           result;

    always_comb begin
        // 10 or 01 seeds the regime, arithmetic shift grows the run
        if (!regime_q[SF_W-1]) begin
            pattern = {2'b10, exp_q, frac_q, guard_q, {PW{1'b0}}};
            shifted = pattern >>> regime_q;
        end else begin
            pattern = {2'b01, exp_q, frac_q, guard_q, {PW{1'b0}}};
            shifted = pattern >>> (-regime_q - 1);
        end
    end

    assign body       = shifted[PAT_W-1 -: PW-1];
    assign rnd_guard  = shifted[PAT_W-PW];
    assign rnd_sticky = (|shifted[PAT_W-PW-1:0]) | sticky_q;
    // nearest, ties to even
    assign rounded    = {1'b0, body} + PW'(rnd_guard & (body[0] | rnd_sticky));

    always_comb begin
        case (class_q)
            posit_mac_pkg::RES_ZERO:   res_mag = '0;
            posit_mac_pkg::RES_MAXPOS: res_mag = {1'b0, {(PW-1){1'b1}}};
            default: begin
                res_mag = rounded;
                if (rounded[PW-1]) begin
                    res_mag = {1'b0, {(PW-1){1'b1}}};   // never round past maxpos
                end
            end
        endcase
        result = sign_q ? -res_mag : res_mag;
    end

    always_ff @(posedge clk_i or negedge rstn) begin
        if (!rstn) begin
            vld_o <= 1'b0;
            acc_o <= '0;
        end else begin
            vld_o <= s1_vld_q;
            if (s1_vld_q) begin
                acc_o <= result;    // held until the next sum
            end
        end
    end

endmodule

`default_nettype wire

// ==== verilog/posit_mac_pkg.sv ====
`default_nettype none

package posit_mac_pkg;

    // ------------------------------
    // posit format
    // ------------------------------
    localparam int POSIT_W  = 8;
    localparam int POSIT_ES = 2;
    localparam int MAX_SF   = 24;   // scale factor of maxpos
    localparam int FRAC_W   = 3;    // longest stored fraction
    localparam int SF_W     = 8;    // holds product range of +/-48

    // ------------------------------
    // quire layout
    // ------------------------------
    // lsb weighs 2^-54, minpos squared lands on bit 6
    localparam int QUIRE_FRAC = 54;
    // 2^49 product range, 7 carry bits, sign
    localparam int QUIRE_W    = 112;

    // one operand after decoding
    typedef struct packed {
        logic                   sign;
        logic                   zero;
        logic signed [SF_W-1:0] sf;     // regime * 4 + exponent
        logic [FRAC_W:0]        frac;   // hidden bit on top
    } decoded_t;

    // registered decoder output
    typedef struct packed {
        logic     vld;
        decoded_t weight;
        decoded_t data;
    } operand_pair_t;

    // aligned product or finished sum
    typedef struct packed {
        logic                      vld;
        logic signed [QUIRE_W-1:0] value;
    } quire_word_t;

    typedef enum logic {
        ACC_IDLE,
        ACC_SUMMING
    } acc_state_e;

    typedef enum logic [1:0] {
        RES_ZERO,
        RES_NORMAL,
        RES_MAXPOS
    } result_class_e;

endpackage

`default_nettype wire

// ==== verilog/posit_mac_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module posit_mac_top #(
    parameter int ACC_LEN = 4
) (
    input  logic                              clk_i,
    input  logic                              rstn,
    input  logic                              vld_i,
    input  logic [posit_mac_pkg::POSIT_W-1:0] weight_i,
    input  logic [posit_mac_pkg::POSIT_W-1:0] data_i,
    output logic [posit_mac_pkg::POSIT_W-1:0] acc_o,
    output logic                              vld_o
);

    posit_mac_pkg::operand_pair_t pair;
    posit_mac_pkg::quire_word_t   prod;     // aligned product
    posit_mac_pkg::quire_word_t   sum;      // finished group

    // ------------------------------
    // decode, multiply, sum, encode
    // ------------------------------
    posit_decoder u_decoder (
        .clk_i    (clk_i),
        .rstn     (rstn),
        .vld_i    (vld_i),
        .weight_i (weight_i),
        .data_i   (data_i),
        .pair_o   (pair)
    );

    product_aligner u_aligner (
        .clk_i  (clk_i),
        .rstn   (rstn),
        .pair_i (pair),
        .prod_o (prod)
    );

    quire_accumulator #(
        .ACC_LEN (ACC_LEN)
    ) u_accumulator (
        .clk_i  (clk_i),
        .rstn   (rstn),
        .prod_i (prod),
        .sum_o  (sum)
    );

    posit_encoder u_encoder (
        .clk_i (clk_i),
        .rstn  (rstn),
        .sum_i (sum),
        .acc_o (acc_o),
        .vld_o (vld_o)
    );

endmodule

`default_nettype wire

// ==== verilog/product_aligner.sv ====
`timescale 1ns/100ps
`default_nettype none

module product_aligner (
    input  logic                         clk_i,
    input  logic                         rstn,
    input  posit_mac_pkg::operand_pair_t pair_i,
    output posit_mac_pkg::quire_word_t   prod_o
);

    localparam int FRAC_W    = posit_mac_pkg::FRAC_W;
    localparam int SF_W      = posit_mac_pkg::SF_W;
    localparam int QUIRE_W   = posit_mac_pkg::QUIRE_W;
    localparam int PROD_FRAC = 2 * FRAC_W;      // 2.6 fixed point

    logic [2*FRAC_W+1:0]       frac_prod;
    logic signed [SF_W-1:0]    sf_sum;
    logic [SF_W-1:0]           shamt;
    logic [QUIRE_W-1:0]        placed;
    logic                      prod_sign;
    logic                      prod_zero;
    logic                      vld_q;
    logic signed [QUIRE_W-1:0] value_q;

    assign frac_prod = pair_i.weight.frac * pair_i.data.frac;
    assign sf_sum    = pair_i.weight.sf + pair_i.data.sf;
    assign prod_sign = pair_i.weight.sign ^ pair_i.data.sign;
    assign prod_zero = pair_i.weight.zero | pair_i.data.zero;

    // binary point of the 2.6 product moves to QUIRE_FRAC
    assign shamt  = SF_W'(posit_mac_pkg::QUIRE_FRAC - PROD_FRAC) + sf_sum;
    assign placed = QUIRE_W'(frac_prod) << shamt;

    always_ff @(posedge clk_i or negedge rstn) begin
        if (!rstn) begin
            vld_q <= 1'b0;
        end else begin
            vld_q <= pair_i.vld;    // zero products still count
        end
    end

    always_ff @(posedge clk_i) begin
        if (pair_i.vld) begin
            if (prod_zero) begin
                value_q <= '0;
            end else begin
                value_q <= prod_sign ? -placed : placed;
            end
        end
    end

    assign prod_o.vld   = vld_q;
    assign prod_o.value = value_q;

endmodule

`default_nettype wire

// ==== verilog/quire_accumulator.sv ====
`timescale 1ns/100ps
`default_nettype none

module quire_accumulator #(
    parameter int ACC_LEN = 4
) (
    input  logic                       clk_i,
    input  logic                       rstn,
    input  posit_mac_pkg::quire_word_t prod_i,
    output posit_mac_pkg::quire_word_t sum_o
);

    localparam int QUIRE_W = posit_mac_pkg::QUIRE_W;
    localparam int CNT_W   = $clog2(ACC_LEN) + 1;

    posit_mac_pkg::acc_state_e  state_q;
    logic [CNT_W-1:0]           count_q;
    logic signed [QUIRE_W-1:0]  partial_q;
    logic signed [QUIRE_W-1:0]  next_sum;
    logic                       last_prod;
    logic                       sum_vld_q;
    logic signed [QUIRE_W-1:0]  sum_q;

    // a fresh group starts from the product itself
    always_comb begin
        next_sum = prod_i.value;
        if (state_q == posit_mac_pkg::ACC_SUMMING) begin
            next_sum = partial_q + prod_i.value;
        end
    end

    assign last_prod = prod_i.vld && (count_q == CNT_W'(ACC_LEN - 1));

    always_ff @(posedge clk_i or negedge rstn) begin
        if (!rstn) begin
            state_q   <= posit_mac_pkg::ACC_IDLE;
            count_q   <= '0;
            partial_q <= '0;
            sum_vld_q <= 1'b0;
        end else begin
            sum_vld_q <= last_prod;
            if (last_prod) begin
                state_q   <= posit_mac_pkg::ACC_IDLE;
                count_q   <= '0;
                partial_q <= '0;
            end else if (prod_i.vld) begin
                state_q   <= posit_mac_pkg::ACC_SUMMING;
                count_q   <= count_q + 1'b1;
                partial_q <= next_sum;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (last_prod) begin
            sum_q <= next_sum;
        end
    end

    assign sum_o.vld   = sum_vld_q;
    assign sum_o.value = sum_q;

endmodule

`default_nettype wire
